// File: verilog/matmul_cfg.svh
// Sizes are fixed at compile time; MATMUL_LEN_W must hold MATMUL_K_MAX, and ACC_W must hold 16 full-scale products
`ifndef MATMUL_CFG_SVH
`define MATMUL_CFG_SVH

// Datapath geometry
`define MATMUL_WIDTH   4
`define MATMUL_DATA_W  8
`define MATMUL_ACC_W   20

// Job length, K from 0 to MATMUL_K_MAX
`define MATMUL_LEN_W   5
`define MATMUL_K_MAX   16

// Peripheral port
`define MATMUL_REG_W   32
`define MATMUL_ADDR_W  2

// Word addresses of the register map
`define MATMUL_ADDR_LEN     2'd0
`define MATMUL_ADDR_TRIGGER 2'd1
`define MATMUL_ADDR_STATUS  2'd2

`endif

// File: verilog/matmul_pkg.sv
// Shared types; widths come from matmul_cfg.svh, address 3 of the register map is unused
`include "matmul_cfg.svh"

package matmul_pkg;

  // Register map of the peripheral port
  typedef enum logic [`MATMUL_ADDR_W-1:0] {
    REG_LEN     = `MATMUL_ADDR_LEN,
    REG_TRIGGER = `MATMUL_ADDR_TRIGGER,
    REG_STATUS  = `MATMUL_ADDR_STATUS
  } reg_addr_e;

  typedef enum logic [1:0] {
    IDLE,
    COMPUTE,
    STORE
  } sched_state_e;

  // Stream payloads
  typedef logic [`MATMUL_DATA_W-1:0]                    elem_t;
  typedef logic [`MATMUL_WIDTH-1:0][`MATMUL_DATA_W-1:0] x_vec_t;
  typedef logic [`MATMUL_WIDTH-1:0][`MATMUL_ACC_W-1:0]  z_vec_t;

  // Peripheral request, wen high means write
  typedef struct packed {
    logic                      req;
    logic                      wen;
    logic [`MATMUL_ADDR_W-1:0] add;
    logic [`MATMUL_REG_W-1:0]  data;
  } periph_req_t;

  typedef struct packed {
    logic                     gnt;
    logic                     r_valid;
    logic [`MATMUL_REG_W-1:0] r_data;
  } periph_rsp_t;

  typedef struct packed {
    logic                     start;
    logic [`MATMUL_LEN_W-1:0] len;
  } job_cfg_t;

  // Everything the scheduler drives, compared as one word by the voter
  typedef struct packed {
    sched_state_e state;
    logic         x_ready;
    logic         w_ready;
    logic         acc_clear;
    logic         acc_en;
    logic         z_valid;
    logic         done;
  } sched_out_t;

endpackage

// File: verilog/matmul_ctrl.sv
// Register file: gnt is combinational, reads answer one cycle later, triggers while busy are dropped
`include "matmul_cfg.svh"

module matmul_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  matmul_pkg::periph_req_t periph_req_i,
  output matmul_pkg::periph_rsp_t periph_rsp_o,
  output matmul_pkg::job_cfg_t    job_o,
  input  logic                    done_i,
  input  logic                    fault_i,
  output logic                    busy_o,
  output logic                    evt_o
);

  localparam int unsigned REG_W = `MATMUL_REG_W;
  localparam int unsigned LEN_W = `MATMUL_LEN_W;
  localparam int unsigned K_MAX = `MATMUL_K_MAX;

  matmul_pkg::reg_addr_e addr;
  logic                  wr_en;
  logic                  rd_en;
  logic [LEN_W-1:0]      len_wr;
  logic [LEN_W-1:0]      len_q;
  logic                  start_q;
  logic                  busy_q;
  logic                  evt_q;
  logic                  r_valid_q;
  logic [REG_W-1:0]      r_data_d;
  logic [REG_W-1:0]      r_data_q;

  assign addr  = matmul_pkg::reg_addr_e'(periph_req_i.add);
  assign wr_en = periph_req_i.req & periph_req_i.wen;
  assign rd_en = periph_req_i.req & ~periph_req_i.wen;

  // Lengths above K_MAX saturate
  assign len_wr = (periph_req_i.data > REG_W'(K_MAX)) ? LEN_W'(K_MAX)
                                                      : periph_req_i.data[LEN_W-1:0];

  always_comb begin
    case (addr)
      matmul_pkg::REG_LEN:    r_data_d = REG_W'(len_q);
      matmul_pkg::REG_STATUS: r_data_d = REG_W'({fault_i, busy_q});
      default:                r_data_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      len_q     <= '0;
      start_q   <= 1'b0;
      busy_q    <= 1'b0;
      evt_q     <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      // A start already in flight counts as busy
      start_q   <= wr_en && (addr == matmul_pkg::REG_TRIGGER) && !busy_q && !start_q;
      evt_q     <= done_i;
      r_valid_q <= rd_en;
      if (wr_en && (addr == matmul_pkg::REG_LEN)) begin
        len_q <= len_wr;
      end
      if (start_q) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      r_data_q <= r_data_d;
    end
  end

  assign job_o.start          = start_q;
  assign job_o.len            = len_q;
  assign periph_rsp_o.gnt     = periph_req_i.req;
  assign periph_rsp_o.r_valid = r_valid_q;
  assign periph_rsp_o.r_data  = r_data_q;
  assign busy_o               = busy_q;
  assign evt_o                = evt_q;

  // Every response belongs to a read granted on the previous edge
  a_rvalid_after_read : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    periph_rsp_o.r_valid |-> $past(rd_en && periph_rsp_o.gnt));

endmodule

// File: verilog/matmul_scheduler.sv
// Job FSM: X and W are taken jointly, one beat per edge at most; len is sampled on start
`include "matmul_cfg.svh"

module matmul_scheduler (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  matmul_pkg::job_cfg_t   job_i,
  input  logic                   x_valid_i,
  input  logic                   w_valid_i,
  input  logic                   z_ready_i,
  output matmul_pkg::sched_out_t sched_o
);

  localparam int unsigned LEN_W = `MATMUL_LEN_W;

  matmul_pkg::sched_state_e state_q;
  matmul_pkg::sched_state_e state_d;
  logic [LEN_W-1:0]         cnt_q;
  logic [LEN_W-1:0]         cnt_d;
  logic [LEN_W-1:0]         len_q;
  logic                     launch;
  logic                     beat;

  assign launch = (state_q == matmul_pkg::IDLE) & job_i.start;
  assign beat   = (state_q == matmul_pkg::COMPUTE) & x_valid_i & w_valid_i;
  assign cnt_d  = cnt_q + LEN_W'(1);

  always_comb begin
    state_d = state_q;
    case (state_q)
      matmul_pkg::IDLE: begin
        // Zero-length jobs skip straight to the result
        if (job_i.start) begin
          state_d = (job_i.len == '0) ? matmul_pkg::STORE : matmul_pkg::COMPUTE;
        end
      end
      matmul_pkg::COMPUTE: begin
        if (beat && (cnt_d == len_q)) begin
          state_d = matmul_pkg::STORE;
        end
      end
      matmul_pkg::STORE: begin
        if (z_ready_i) begin
          state_d = matmul_pkg::IDLE;
        end
      end
      default: state_d = matmul_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= matmul_pkg::IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (launch) begin
        cnt_q <= '0;
      end else if (beat) begin
        cnt_q <= cnt_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (launch) begin
      len_q <= job_i.len;
    end
  end

  always_comb begin
    sched_o.state     = state_q;
    sched_o.x_ready   = beat;
    sched_o.w_ready   = beat;
    sched_o.acc_clear = launch;
    sched_o.acc_en    = beat;
    sched_o.z_valid   = (state_q == matmul_pkg::STORE);
    sched_o.done      = (state_q == matmul_pkg::STORE) & z_ready_i;
  end

  // Result stays offered until the sink takes it
  a_z_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (sched_o.z_valid && !z_ready_i) |=> sched_o.z_valid);

endmodule

// File: verilog/matmul_lockstep.sv
// Two scheduler copies in lockstep; replica 0 drives the design, a mismatch sets fault until reset
module matmul_lockstep (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  matmul_pkg::job_cfg_t   job_i,
  input  logic                   x_valid_i,
  input  logic                   w_valid_i,
  input  logic                   z_ready_i,
  output matmul_pkg::sched_out_t sched_o,
  output logic                   fault_o
);

  localparam int unsigned NUM_REP = 2;

  matmul_pkg::sched_out_t [NUM_REP-1:0] rep_out;
  logic                                 fault_q;

  for (genvar r = 0; r < NUM_REP; r++) begin : gen_replica
    matmul_scheduler i_scheduler (
      .clk_i     ( clk_i      ),
      .rst_n_i   ( rst_n_i    ),
      .job_i     ( job_i      ),
      .x_valid_i ( x_valid_i  ),
      .w_valid_i ( w_valid_i  ),
      .z_ready_i ( z_ready_i  ),
      .sched_o   ( rep_out[r] )
    );
  end

  // Whole-struct compare, any bit differing counts
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      fault_q <= 1'b0;
    end else if (rep_out[0] != rep_out[1]) begin
      fault_q <= 1'b1;
    end
  end

  assign sched_o = rep_out[0];
  assign fault_o = fault_q;

  a_fault_sticky : assert property (@(posedge clk_i)
    (fault_o && rst_n_i) |=> fault_o);

endmodule

// File: verilog/matmul_engine.sv
// MAC lanes with unsigned operands; accumulators wrap modulo 2^ACC_W, clear has priority over enable
`include "matmul_cfg.svh"

module matmul_engine (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               acc_clear_i,
  input  logic               acc_en_i,
  input  matmul_pkg::x_vec_t x_data_i,
  input  matmul_pkg::elem_t  w_data_i,
  output matmul_pkg::z_vec_t z_data_o
);

  localparam int unsigned WIDTH  = `MATMUL_WIDTH;
  localparam int unsigned DATA_W = `MATMUL_DATA_W;
  localparam int unsigned ACC_W  = `MATMUL_ACC_W;
  localparam int unsigned PROD_W = 2 * DATA_W;

  matmul_pkg::z_vec_t acc_q;
  matmul_pkg::z_vec_t acc_d;

  for (genvar i = 0; i < WIDTH; i++) begin : gen_lane
    logic [PROD_W-1:0] prod;

    // W is broadcast to every lane
    assign prod     = x_data_i[i] * w_data_i;
    assign acc_d[i] = acc_q[i] + {{(ACC_W-PROD_W){1'b0}}, prod};
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || acc_clear_i) begin
      acc_q <= '0;
    end else if (acc_en_i) begin
      acc_q <= acc_d;
    end
  end

  assign z_data_o = acc_q;

endmodule

// File: verilog/matmul_top.sv
// Top level: X, W and Z are bare valid/ready streams, senders must hold data while valid is high
module matmul_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  matmul_pkg::periph_req_t periph_req_i,
  output matmul_pkg::periph_rsp_t periph_rsp_o,
  input  logic                    x_valid_i,
  input  matmul_pkg::x_vec_t      x_data_i,
  output logic                    x_ready_o,
  input  logic                    w_valid_i,
  input  matmul_pkg::elem_t       w_data_i,
  output logic                    w_ready_o,
  output logic                    z_valid_o,
  output matmul_pkg::z_vec_t      z_data_o,
  input  logic                    z_ready_i,
  output logic                    busy_o,
  output logic                    evt_o,
  output logic                    fault_o
);

  matmul_pkg::job_cfg_t   job;
  matmul_pkg::sched_out_t sched;
  logic                   fault;

  matmul_ctrl i_ctrl (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .periph_req_i ( periph_req_i ),
    .periph_rsp_o ( periph_rsp_o ),
    .job_o        ( job          ),
    .done_i       ( sched.done   ),
    .fault_i      ( fault        ),
    .busy_o       ( busy_o       ),
    .evt_o        ( evt_o        )
  );

  matmul_lockstep i_lockstep (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .job_i     ( job       ),
    .x_valid_i ( x_valid_i ),
    .w_valid_i ( w_valid_i ),
    .z_ready_i ( z_ready_i ),
    .sched_o   ( sched     ),
    .fault_o   ( fault     )
  );

  matmul_engine i_engine (
    .clk_i       ( clk_i           ),
    .rst_n_i     ( rst_n_i         ),
    .acc_clear_i ( sched.acc_clear ),
    .acc_en_i    ( sched.acc_en    ),
    .x_data_i    ( x_data_i        ),
    .w_data_i    ( w_data_i        ),
    .z_data_o    ( z_data_o        )
  );

  // Handshake outputs come from replica 0
  assign x_ready_o = sched.x_ready;
  assign w_ready_o = sched.w_ready;
  assign z_valid_o = sched.z_valid;
  assign fault_o   = fault;

endmodule

// File: testbench/tb_matmul_top.sv
// Jobs run one at a time with xorshift stimulus from a fixed seed; the run stops at the first error
`include "matmul_cfg.svh"

module tb_matmul_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned HALF_PERIOD     = 20;
  localparam int unsigned K_MAX           = `MATMUL_K_MAX;
  localparam int unsigned WIDTH           = `MATMUL_WIDTH;
  localparam int unsigned WATCHDOG_CYCLES = 4 * K_MAX * 4 + 400;

  logic                    clk_i = 1'b0;
  logic                    rst_n_i;
  matmul_pkg::periph_req_t periph_req_i;
  matmul_pkg::periph_rsp_t periph_rsp_o;
  matmul_pkg::x_vec_t      x_data_i;
  matmul_pkg::elem_t       w_data_i;
  matmul_pkg::z_vec_t      z_data_o;
  logic                    x_valid_i;
  logic                    w_valid_i;
  logic                    z_ready_i;
  logic                    x_ready_o;
  logic                    w_ready_o;
  logic                    z_valid_o;
  logic                    busy_o;
  logic                    evt_o;
  logic                    fault_o;

  // Reference model and handshake monitors
  matmul_pkg::z_vec_t      exp_q [$];
  matmul_pkg::z_vec_t      exp_z;
  logic [31:0]             exp_rdata;
  logic [31:0]             rng_state;
  logic                    xw_fire;
  logic                    z_fire;
  logic                    rd_gnt;
  logic                    trig_idle;

  matmul_top i_matmul_top (.*);

  always #(HALF_PERIOD) clk_i = ~clk_i;

  assign rd_gnt    = periph_req_i.req && !periph_req_i.wen && periph_rsp_o.gnt;
  assign trig_idle = periph_req_i.req && periph_req_i.wen && !busy_o &&
                     (periph_req_i.add == matmul_pkg::REG_TRIGGER);

  // Transfers at the last rising edge, picked up by the driver on the falling edge
  always @(posedge clk_i) begin
    xw_fire <= rst_n_i && x_valid_i && x_ready_o;
    z_fire  <= rst_n_i && z_valid_o && z_ready_i;
  end

  function automatic logic [31:0] xorshift32();
    logic [31:0] s;
    s = rng_state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rng_state = s;
    return s;
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  // Starts and ends just after a falling edge; a read also waits out its response cycle
  task automatic access_reg(input logic wen, input matmul_pkg::reg_addr_e addr,
                            input logic [31:0] data);
    if (!wen) begin
      exp_rdata = data;
    end
    periph_req_i = {1'b1, wen, addr, data};
    @(negedge clk_i);
    periph_req_i = '0;
    if (!wen) begin
      @(negedge clk_i);
    end
  endtask

  task automatic run_job(input logic [31:0] len_raw);
    matmul_pkg::x_vec_t xs [K_MAX];
    matmul_pkg::elem_t  ws [K_MAX];
    matmul_pkg::z_vec_t sum;
    logic [31:0]        rnd;
    int unsigned        k;
    int unsigned        sent;
    k   = (len_raw > K_MAX) ? K_MAX : len_raw;
    sum = '0;
    // Lane i sums x[i] * w over the job, wrapping at the accumulator width
    for (int unsigned b = 0; b < k; b++) begin
      xs[b] = xorshift32();
      rnd   = xorshift32();
      ws[b] = rnd[7:0];
      for (int unsigned i = 0; i < WIDTH; i++) begin
        sum[i] = sum[i] + xs[b][i] * ws[b];
      end
    end
    exp_q.push_back(sum);
    exp_z = exp_q[0];
    access_reg(1'b1, matmul_pkg::REG_LEN, len_raw);
    access_reg(1'b0, matmul_pkg::REG_LEN, k);
    access_reg(1'b1, matmul_pkg::REG_TRIGGER, '0);
    @(negedge clk_i);
    // busy_o is high here, so this trigger must be dropped
    access_reg(1'b1, matmul_pkg::REG_TRIGGER, '0);
    sent = 0;
    while (!z_fire) begin
      if (xw_fire) begin
        sent++;
        x_valid_i = 1'b0;
        w_valid_i = 1'b0;
      end
      rnd = xorshift32();
      if (sent < k) begin
        x_data_i  = xs[sent];
        w_data_i  = ws[sent];
        x_valid_i = x_valid_i || (rnd[1:0] != 2'b00);
        w_valid_i = w_valid_i || (rnd[3:2] != 2'b00);
      end
      z_ready_i = rnd[4];
      @(negedge clk_i);
    end
    z_ready_i = 1'b0;
    void'(exp_q.pop_front());
    exp_z = (exp_q.size() > 0) ? exp_q[0] : '0;
    // Idle with no fault, so the status word reads zero
    access_reg(1'b0, matmul_pkg::REG_STATUS, 32'h0);
  endtask

  a_grant : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    periph_rsp_o.gnt == periph_req_i.req)
    else stop_on_error($sformatf("FAILED t=%0t periph_rsp_o.gnt: got %0b expected %0b",
                                 $time, $sampled(periph_rsp_o.gnt),
                                 $sampled(periph_req_i.req)));
  a_read_response : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    periph_rsp_o.r_valid == $past(rd_gnt))
    else stop_on_error("r_valid did not come exactly one cycle after a granted read");
  a_read_data : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    periph_rsp_o.r_valid |-> periph_rsp_o.r_data == exp_rdata)
    else stop_on_error($sformatf("FAILED t=%0t periph_rsp_o.r_data: got %0h expected %0h",
                                 $time, $sampled(periph_rsp_o.r_data), exp_rdata));
  a_busy_rise : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    trig_idle |-> ##1 !busy_o ##1 busy_o)
    else stop_on_error("busy_o did not rise in the second cycle after a trigger write");
  a_busy_cause : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(busy_o) |-> $past(trig_idle, 2))
    else stop_on_error("busy_o rose without an idle trigger write two cycles before");
  a_z_data : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (z_valid_o && z_ready_i) |-> z_data_o == exp_z)
    else stop_on_error($sformatf("FAILED t=%0t z_data_o: got %h expected %h",
                                 $time, $sampled(z_data_o), exp_z));
  a_z_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (z_valid_o && !z_ready_i) |=> z_valid_o && $stable(z_data_o))
    else stop_on_error("Z beat changed or vanished while z_ready_i was low");
  a_job_end : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (z_valid_o && z_ready_i) |=> evt_o && !busy_o ##1 !evt_o)
    else stop_on_error("evt_o was not a single pulse with busy_o low after Z was taken");
  a_ready : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (x_ready_o || w_ready_o) |-> x_ready_o && w_ready_o && busy_o && x_valid_i && w_valid_i)
    else stop_on_error("X/W ready was high outside a busy job or without both valids");
  a_no_fault : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !fault_o)
    else stop_on_error($sformatf("FAILED t=%0t fault_o: got %0b expected 0",
                                 $time, $sampled(fault_o)));

  initial begin
    rng_state    = 32'hc2d6;
    rst_n_i      = 1'b0;
    periph_req_i = '0;
    x_valid_i    = 1'b0;
    x_data_i     = '0;
    w_valid_i    = 1'b0;
    w_data_i     = '0;
    z_ready_i    = 1'b0;
    exp_rdata    = '0;
    exp_z        = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    // K = 0, a length that clamps to 16, then two random lengths
    run_job(32'd0);
    run_job(32'd40);
    run_job(32'd1 + (xorshift32() % 32'd15));
    run_job(32'd1 + (xorshift32() % 32'd15));
    repeat (2) @(negedge clk_i);
    $display("Result: PASSED");
    $finish;
  end

  // Worst case of four full-length jobs with slow handshakes, plus margin
  initial begin
    #(WATCHDOG_CYCLES * 2 * HALF_PERIOD);
    stop_on_error($sformatf("Timeout: the jobs did not finish within %0d cycles",
                            WATCHDOG_CYCLES));
  end

endmodule

// File: compile.f
+incdir+verilog
verilog/matmul_pkg.sv
verilog/matmul_ctrl.sv
verilog/matmul_scheduler.sv
verilog/matmul_lockstep.sv
verilog/matmul_engine.sv
verilog/matmul_top.sv
testbench/tb_matmul_top.sv

// File: Bender.yml
package:
  name: matmul

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/matmul_pkg.sv
      - verilog/matmul_ctrl.sv
      - verilog/matmul_scheduler.sv
      - verilog/matmul_lockstep.sv
      - verilog/matmul_engine.sv
      - verilog/matmul_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_matmul_top.sv
